//--- z80_bus_pkg.sv
/*
  Shared types and constants for the Z80-style bus-cycle engine.
  Cycle kinds are plain 3-bit codes driven by the requester.
  AUTO_WAIT_IO sets the forced wait count of I/O and interrupt-acknowledge cycles.
  The automatic-wait counter width is derived from it.
*/
`default_nettype none

package z80_bus_pkg;

  typedef logic [15:0] addr_t;     // Bus address
  typedef logic [7:0]  data_t;     // Bus data byte
  typedef logic [6:0]  refresh_t;  // DRAM refresh row

  // Machine-cycle kind as presented on the request side
  typedef logic [2:0] cycle_kind_t;

  localparam cycle_kind_t KIND_FETCH   = 3'd0;  // M1 opcode fetch plus refresh
  localparam cycle_kind_t KIND_MEM_RD  = 3'd1;
  localparam cycle_kind_t KIND_MEM_WR  = 3'd2;
  localparam cycle_kind_t KIND_IO_RD   = 3'd3;
  localparam cycle_kind_t KIND_IO_WR   = 3'd4;
  localparam cycle_kind_t KIND_INT_ACK = 3'd5;  // M1 with IORQ, vector on din

  // Forced TW count for I/O and interrupt acknowledge
  localparam int AUTO_WAIT_IO = 1;
  localparam int AUTO_WAIT_W  = (AUTO_WAIT_IO > 1) ? $clog2(AUTO_WAIT_IO + 1) : 1;

  typedef logic [AUTO_WAIT_W-1:0] wait_cnt_t;  // Automatic wait down counter

  // T-states of one machine cycle
  typedef enum logic [2:0] {
    T_IDLE,
    T1,
    T2,
    TW,
    T3,
    T4
  } tstate_e;

  // Request handshake states
  typedef enum logic [1:0] {
    HS_IDLE,
    HS_RUN,
    HS_ACK
  } hs_state_e;

  // Kinds that get the automatic I/O wait
  function automatic logic kind_is_io(cycle_kind_t k);
    return (k == KIND_IO_RD) || (k == KIND_IO_WR) || (k == KIND_INT_ACK);
  endfunction

  // Kinds that latch a byte from din
  function automatic logic kind_is_read(cycle_kind_t k);
    return (k == KIND_FETCH) || (k == KIND_MEM_RD) || (k == KIND_IO_RD) ||
           (k == KIND_INT_ACK);
  endfunction

endpackage

`default_nettype wire

//--- tstate_timer.sv
/*
  T-state sequencer for one machine cycle.
  wait_n is sampled in T2 and TW only and stretches the cycle without limit.
  I/O and int-ack add AUTO_WAIT_IO forced waits after the external ones.
  wait_hold and cycle_done are combinational from the state and wait_n.
*/
`timescale 1ns/10ps
`default_nettype none

module tstate_timer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,       // One-cycle pulse from the FSM
  input  z80_bus_pkg::cycle_kind_t kind,
  input  logic                     wait_n,
  output z80_bus_pkg::tstate_e     tstate,
  output logic                     wait_hold,   // Next T-state is TW
  output logic                     cycle_done   // High in the last T-state
);

  import z80_bus_pkg::*;

  wait_cnt_t auto_cnt;     // Remaining forced waits
  logic      in_wait_win;  // T2 or TW

  assign in_wait_win = (tstate == T2) || (tstate == TW);

  // External wait first, then the forced ones
  assign wait_hold = in_wait_win && (!wait_n || (auto_cnt != '0));

  // Fetch carries the refresh T4, others end in T3
  assign cycle_done = (tstate == T4) || ((tstate == T3) && (kind != KIND_FETCH));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tstate   <= T_IDLE;
      auto_cnt <= '0;
    end else begin
      case (tstate)
        T_IDLE: begin
          if (start) begin
            tstate   <= T1;
            auto_cnt <= kind_is_io(kind) ? wait_cnt_t'(AUTO_WAIT_IO) : '0;
          end
        end
        T1: tstate <= T2;
        T2, TW: begin
          if (wait_hold) begin
            tstate <= TW;
            if (wait_n) auto_cnt <= auto_cnt - wait_cnt_t'(1);  // Only when no ext wait
          end else begin
            tstate <= T3;
          end
        end
        T3: tstate <= (kind == KIND_FETCH) ? T4 : T_IDLE;
        T4: tstate <= T_IDLE;
        default: tstate <= T_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- mcycle_fsm.sv
/*
  Four-phase request handshake for one machine cycle at a time.
  kind_in is registered when req is accepted and held until the next request.
  capture is combinational and marks the accepting edge for the address registers.
  ack rises one clock after the timer finishes and falls one clock after req drops.
*/
`timescale 1ns/10ps
`default_nettype none

module mcycle_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req,
  input  z80_bus_pkg::cycle_kind_t kind_in,
  input  logic                     cycle_done,
  output logic                     start,    // Kicks the T-state timer
  output logic                     capture,  // Register addr and wdata on this edge
  output z80_bus_pkg::cycle_kind_t kind,     // Kind of the cycle in flight
  output logic                     ack
);

  import z80_bus_pkg::*;

  hs_state_e state;

  // Request is taken on the edge where we sit idle with req high
  assign capture = (state == HS_IDLE) && req;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= HS_IDLE;
      start <= 1'b0;
      ack   <= 1'b0;
      kind  <= KIND_FETCH;
    end else begin
      start <= 1'b0;  // Single-cycle pulse
      case (state)
        HS_IDLE: begin
          if (req) begin
            kind  <= kind_in;
            start <= 1'b1;
            state <= HS_RUN;
          end
        end

        // Bus cycle runs in the timer
        HS_RUN: begin
          if (cycle_done) begin
            state <= HS_ACK;
          end
        end

        HS_ACK: begin
          if (!ack) begin
            ack <= 1'b1;     // rdata is already latched here
          end else if (!req) begin
            ack   <= 1'b0;
            state <= HS_IDLE;
          end
          // Held req keeps us here and blocks new cycles
        end

        default: begin
          state <= HS_IDLE;
          ack   <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- bus_strobe_gen.sv
/*
  Registered Z80 control strobes, all active low.
  Each strobe is evaluated from the present T-state, so it changes one edge later.
  Read and write strobes share the same window and write timing is not selectable.
  Refresh mreq_n covers T3 of a fetch and rfsh_n covers T3 and T4.
*/
`timescale 1ns/10ps
`default_nettype none

module bus_strobe_gen (
  input  logic                     clk,
  input  logic                     reset,
  input  z80_bus_pkg::cycle_kind_t kind,
  input  z80_bus_pkg::tstate_e     tstate,
  input  logic                     wait_hold,
  output logic                     mreq_n,
  output logic                     iorq_n,
  output logic                     rd_n,
  output logic                     wr_n,
  output logic                     m1_n,
  output logic                     rfsh_n
);

  import z80_bus_pkg::*;

  logic in_wait_win;  // T2 or TW
  logic access_win;   // Strobes low on the next clock
  logic last_wait;    // Leaving the final T2/TW

  assign in_wait_win = (tstate == T2) || (tstate == TW);
  assign access_win  = (tstate == T1) || (in_wait_win && wait_hold);
  assign last_wait   = in_wait_win && !wait_hold;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      m1_n   <= 1'b1;
      rfsh_n <= 1'b1;
    end else begin
      mreq_n <= 1'b1;  // Everything idles high
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      m1_n   <= 1'b1;
      rfsh_n <= 1'b1;

      if (access_win) begin
        case (kind)
          KIND_FETCH: begin
            mreq_n <= 1'b0;
            rd_n   <= 1'b0;
            m1_n   <= 1'b0;
          end
          KIND_MEM_RD: begin
            mreq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
          KIND_MEM_WR: begin
            mreq_n <= 1'b0;
            wr_n   <= 1'b0;
          end
          KIND_IO_RD: begin
            iorq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
          KIND_IO_WR: begin
            iorq_n <= 1'b0;
            wr_n   <= 1'b0;
          end
          KIND_INT_ACK: begin
            iorq_n <= 1'b0;  // Vector read without rd_n
            m1_n   <= 1'b0;
          end
          default: begin
            mreq_n <= 1'b1;  // Unknown kind, bus stays quiet
          end
        endcase
      end

      // Refresh half of the opcode fetch
      if (kind == KIND_FETCH) begin
        if (last_wait || (tstate == T3)) rfsh_n <= 1'b0;
        if (last_wait) mreq_n <= 1'b0;  // One clock, during T3
      end
    end
  end

endmodule

`default_nettype wire

//--- bus_data_path.sv
/*
  Address and data side of the bus engine.
  addr and wdata are held from capture until the next request.
  rdata is loaded on the edge that leaves the last T2/TW of a read-type cycle.
  The refresh row counter advances once per fetch, at the end of T4.
*/
`timescale 1ns/10ps
`default_nettype none

module bus_data_path (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     capture,
  input  z80_bus_pkg::cycle_kind_t kind,
  input  z80_bus_pkg::tstate_e     tstate,
  input  logic                     wait_hold,
  input  z80_bus_pkg::addr_t       addr,
  input  z80_bus_pkg::data_t       wdata,
  input  z80_bus_pkg::data_t       din,
  output z80_bus_pkg::addr_t       addr_bus,
  output z80_bus_pkg::data_t       dout,
  output z80_bus_pkg::data_t       rdata
);

  import z80_bus_pkg::*;

  localparam int PAD_W = $bits(addr_t) - $bits(refresh_t);

  addr_t    addr_q;      // Request address
  data_t    wdata_q;     // Request write byte
  refresh_t rfsh_cnt;
  logic     in_refresh;  // T3/T4 of a fetch
  logic     read_edge;   // Sample din on this edge

  assign in_refresh = (kind == KIND_FETCH) && ((tstate == T3) || (tstate == T4));
  assign read_edge  = ((tstate == T2) || (tstate == TW)) && !wait_hold &&
                      kind_is_read(kind);

  // Refresh row replaces the address in the second half of M1
  assign addr_bus = in_refresh ? {{PAD_W{1'b0}}, rfsh_cnt} : addr_q;
  assign dout     = wdata_q;

  always_ff @(posedge clk) begin
    if (capture) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  // Strobes are still low on this edge, so din is valid
  always_ff @(posedge clk) begin
    if (read_edge) begin
      rdata <= din;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rfsh_cnt <= '0;
    end else if ((tstate == T4) && (kind == KIND_FETCH)) begin
      rfsh_cnt <= rfsh_cnt + refresh_t'(1);  // Wraps at 128
    end
  end

endmodule

`default_nettype wire

//--- z80_bus_top.sv
/*
  Bus-cycle engine top level.
  One machine cycle per four-phase req/ack exchange on the request side.
  Hold kind, addr and wdata stable while req is high.
  No bus request, halt or NMI handling, and every clock edge is a T-state edge.
*/
`timescale 1ns/10ps
`default_nettype none

module z80_bus_top (
  input  logic                     clk,
  input  logic                     reset,
  // Request side
  input  logic                     req,
  input  z80_bus_pkg::cycle_kind_t kind,
  input  z80_bus_pkg::addr_t       addr,
  input  z80_bus_pkg::data_t       wdata,
  output logic                     ack,
  output z80_bus_pkg::data_t       rdata,
  // External bus
  output z80_bus_pkg::addr_t       addr_bus,
  output z80_bus_pkg::data_t       dout,
  input  z80_bus_pkg::data_t       din,
  input  logic                     wait_n,
  output logic                     mreq_n,
  output logic                     iorq_n,
  output logic                     rd_n,
  output logic                     wr_n,
  output logic                     m1_n,
  output logic                     rfsh_n
);

  import z80_bus_pkg::*;

  logic        start;
  logic        capture;
  cycle_kind_t cyc_kind;    // Registered kind of the running cycle
  tstate_e     tstate;
  logic        wait_hold;
  logic        cycle_done;

  mcycle_fsm u_fsm (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .kind_in    (kind),
    .cycle_done (cycle_done),
    .start      (start),
    .capture    (capture),
    .kind       (cyc_kind),
    .ack        (ack)
  );

  tstate_timer u_timer (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .kind       (cyc_kind),
    .wait_n     (wait_n),
    .tstate     (tstate),
    .wait_hold  (wait_hold),
    .cycle_done (cycle_done)
  );

  bus_strobe_gen u_strobe (
    .clk       (clk),
    .reset     (reset),
    .kind      (cyc_kind),
    .tstate    (tstate),
    .wait_hold (wait_hold),
    .mreq_n    (mreq_n),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .m1_n      (m1_n),
    .rfsh_n    (rfsh_n)
  );

  bus_data_path u_data (
    .clk       (clk),
    .reset     (reset),
    .capture   (capture),
    .kind      (cyc_kind),
    .tstate    (tstate),
    .wait_hold (wait_hold),
    .addr      (addr),
    .wdata     (wdata),
    .din       (din),
    .addr_bus  (addr_bus),
    .dout      (dout),
    .rdata     (rdata)
  );

endmodule

`default_nettype wire

//--- z80_bus_checker.sv
/*
  Protocol assertions for the bus engine, bound into z80_bus_top.
  All checks are off while reset is high.
  viol_cnt is read by the testbench at the end of the run.
*/
`timescale 1ns/10ps
`default_nettype none

module z80_bus_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     req,
  input logic                     ack,
  input z80_bus_pkg::cycle_kind_t kind,
  input z80_bus_pkg::addr_t       addr,
  input z80_bus_pkg::tstate_e     tstate,
  input logic                     mreq_n,
  input logic                     iorq_n,
  input logic                     rd_n,
  input logic                     wr_n,
  input logic                     m1_n,
  input logic                     rfsh_n
);

  import z80_bus_pkg::*;

  int viol_cnt = 0;  // Failed assertion count

  rd_wr_excl: assert property (@(posedge clk) disable iff (reset) rd_n || wr_n)
    else begin
      viol_cnt++;
      $error("rd_n and wr_n low in the same clock");
    end

  // Memory and I/O select exclusive, refresh excepted
  sel_excl: assert property (@(posedge clk) disable iff (reset) mreq_n || iorq_n || !rfsh_n)
    else begin
      viol_cnt++;
      $error("mreq_n and iorq_n low together outside refresh");
    end

  ack_after_req: assert property (@(posedge clk) disable iff (reset) $fell(ack) |-> !$past(req))
    else begin
      viol_cnt++;
      $error("ack dropped while req was still high");
    end

  // Requester must hold its request fields
  req_stable: assert property (@(posedge clk) disable iff (reset)
                               req && $past(req) |-> $stable(addr) && $stable(kind))
    else begin
      viol_cnt++;
      $error("addr or kind changed while req was high");
    end

  idle_quiet: assert property (@(posedge clk) disable iff (reset)
                               (tstate == T_IDLE) |-> &{mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n})
    else begin
      viol_cnt++;
      $error("bus strobe active with the timer idle");
    end

endmodule

bind z80_bus_top z80_bus_checker u_checker (
  .clk    (clk),
  .reset  (reset),
  .req    (req),
  .ack    (ack),
  .kind   (kind),
  .addr   (addr),
  .tstate (tstate),
  .mreq_n (mreq_n),
  .iorq_n (iorq_n),
  .rd_n   (rd_n),
  .wr_n   (wr_n),
  .m1_n   (m1_n),
  .rfsh_n (rfsh_n)
);

`default_nettype wire

//--- tb_z80_bus.sv
/*
  Table-driven testbench for the bus-cycle engine.
  Memory, I/O and vector models answer on din, a wait model drives wait_n.
  External wait counts are random 0 to 3 from seed 49, int-ack cycles take none.
  Expected bytes come from reference copies updated while the table is built.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_z80_bus;

  import z80_bus_pkg::*;

  localparam int    CLK_PERIOD = 40;
  localparam int    N_RAND     = 180;    // Enough fetches to wrap the refresh row
  localparam data_t INT_VEC    = 8'hD7;  // RST 10h as the vector

  typedef struct {
    cycle_kind_t kind;
    addr_t       addr;
    data_t       wdata;
    int          waits;     // External wait clocks
    data_t       exp_data;  // rdata for reads
  } entry_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        req;
  cycle_kind_t kind;
  addr_t       addr;
  data_t       wdata;
  logic        ack;
  data_t       rdata;
  addr_t       addr_bus;
  data_t       dout;
  data_t       din;
  logic        wait_n = 1'b1;  // Owned by the wait model
  logic        mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n;

  data_t      mem [0:65535];      // Bus side memory
  data_t      ref_mem [0:65535];  // Expected contents
  data_t      io [0:255];
  data_t      ref_io [0:255];
  entry_t     tbl [$];
  logic       tbl_ready = 1'b0;
  int         seed = 49;
  int         n_fetch = 0;        // Refresh row of the next fetch
  int         cur_idx = 0;
  int         cur_waits = 0;
  int         wait_left = 0;
  logic       strobe_q = 1'b1;    // rd_n & wr_n at the last falling edge
  logic [6:0] stb_low;
  int         low_cnt [7];        // Clocks each strobe was low this cycle
  addr_t      acc_addr;           // addr_bus in the access window
  data_t      acc_dout;
  addr_t      rfsh_addr;          // addr_bus in refresh
  string      stb_name [7] = '{"rd_n", "wr_n", "mreq_n", "iorq_n", "m1_n", "m1_n&rd_n", "rfsh_n"};

  z80_bus_top dut0 (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Memory, then I/O, then the int-ack vector
  assign din = (!rd_n && !mreq_n) ? mem[addr_bus] :
               (!rd_n && !iorq_n) ? io[addr_bus[7:0]] :
               (!iorq_n && !m1_n) ? INT_VEC : 8'hFF;

  assign stb_low = {!rfsh_n, !m1_n && !rd_n, !m1_n, !iorq_n, !mreq_n, !wr_n, !rd_n};

  // Bus monitor and write side of the models, strobes settled here
  always @(negedge clk) begin
    for (int i = 0; i < 7; i++) begin
      if (stb_low[i]) low_cnt[i] <= low_cnt[i] + 1;
    end
    if (!wr_n && !mreq_n) mem[addr_bus] <= dout;
    if (!wr_n && !iorq_n) io[addr_bus[7:0]] <= dout;
    if (!rd_n || !wr_n || !iorq_n) begin
      acc_addr <= addr_bus;
      acc_dout <= dout;
    end
    if (!rfsh_n) rfsh_addr <= addr_bus;
  end

  // wait_n low for cur_waits clocks once rd_n or wr_n falls
  always @(negedge clk) begin
    if (wait_left > 0) begin
      wait_left = wait_left - 1;
      if (wait_left == 0) wait_n = 1'b1;
    end else if (strobe_q && !(rd_n && wr_n) && (cur_waits > 0)) begin
      wait_n    = 1'b0;
      wait_left = cur_waits;
    end
    strobe_q = rd_n && wr_n;
  end

  function automatic data_t mem_fill(input addr_t a);
    return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h3C;  // Every address bit counts
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h (entry %0d)", name, got, exp, cur_idx);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h (entry %0d)", name, got, exp, cur_idx);
      abort_run();
    end
  endtask

  task automatic check_refresh(input string name, input refresh_t got, input refresh_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h (entry %0d)", name, got, exp, cur_idx);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h (entry %0d)", name, got, exp, cur_idx);
      abort_run();
    end
  endtask

  // Appends one request, reference memories follow the writes in table order
  task automatic add_entry(input cycle_kind_t k, input addr_t a, input data_t wd);
    entry_t e;
    e.kind     = k;
    e.addr     = a;
    e.wdata    = wd;
    e.waits    = (k == KIND_INT_ACK) ? 0 : int'({$random(seed)} % 4);
    e.exp_data = wd;
    case (k)
      KIND_MEM_WR:  ref_mem[a] = wd;
      KIND_IO_WR:   ref_io[a[7:0]] = wd;
      KIND_IO_RD:   e.exp_data = ref_io[a[7:0]];
      KIND_INT_ACK: e.exp_data = INT_VEC;
      default:      e.exp_data = ref_mem[a];  // Fetch and memory read
    endcase
    tbl.push_back(e);
  endtask

  // One four-phase exchange plus all checks on it
  task automatic run_entry(input entry_t e);
    int   lat;
    int   len;
    int   exp_cnt [7];
    logic is_io;
    logic fetch;
    is_io = e.kind inside {KIND_IO_RD, KIND_IO_WR, KIND_INT_ACK};
    fetch = (e.kind == KIND_FETCH);
    len   = 1 + e.waits + (is_io ? AUTO_WAIT_IO : 0);  // Access window in clocks
    lat   = 0;
    @(negedge clk);
    kind      = e.kind;
    addr      = e.addr;
    wdata     = e.wdata;
    cur_waits = e.waits;
    foreach (low_cnt[i]) low_cnt[i] = 0;
    req = 1'b1;
    do begin
      @(negedge clk);
      lat++;
    end while (!ack);
    // ack edge is 4 + len clocks after the sample edge, seen one negedge later
    check_count("ack latency", lat, 1 + 4 + len + (fetch ? 1 : 0));
    if (!(e.kind inside {KIND_MEM_WR, KIND_IO_WR})) check_data("rdata", rdata, e.exp_data);
    req = 1'b0;
    @(negedge clk);
    check_count("ack after req drop", int'(ack), 0);
    exp_cnt[0] = (e.kind inside {KIND_FETCH, KIND_MEM_RD, KIND_IO_RD}) ? len : 0;
    exp_cnt[1] = (e.kind inside {KIND_MEM_WR, KIND_IO_WR}) ? len : 0;
    exp_cnt[2] = is_io ? 0 : len + (fetch ? 1 : 0);  // Refresh adds one mreq_n clock
    exp_cnt[3] = is_io ? len : 0;
    exp_cnt[4] = (fetch || (e.kind == KIND_INT_ACK)) ? len : 0;
    exp_cnt[5] = fetch ? len : 0;
    exp_cnt[6] = fetch ? 2 : 0;                       // T3 and T4
    for (int i = 0; i < 7; i++) begin
      check_count({stb_name[i], " low clocks"}, low_cnt[i], exp_cnt[i]);
    end
    check_addr("addr_bus", acc_addr, e.addr);
    if (e.kind inside {KIND_MEM_WR, KIND_IO_WR}) check_data("dout", acc_dout, e.wdata);
    if (fetch) begin
      check_refresh("refresh row", refresh_t'(rfsh_addr), refresh_t'(n_fetch % 128));
      check_addr("refresh addr_bus", rfsh_addr, addr_t'(n_fetch % 128));
      n_fetch++;
    end
  endtask

  initial begin
    cycle_kind_t rk;
    addr_t       ra;
    data_t       rw;
    reset = 1'b1;
    req   = 1'b0;
    kind  = KIND_FETCH;
    addr  = '0;
    wdata = '0;
    for (int i = 0; i < 65536; i++) begin
      mem[i]     = mem_fill(addr_t'(i));
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < 256; i++) begin
      io[i]     = data_t'(i) ^ 8'h96;
      ref_io[i] = io[i];
    end
    // Directed cycles
    add_entry(KIND_MEM_RD, 16'h1234, 8'h00);
    add_entry(KIND_MEM_WR, 16'h1234, 8'hA5);
    add_entry(KIND_MEM_RD, 16'h1234, 8'h00);  // Reads the write back
    add_entry(KIND_IO_WR, 16'h0042, 8'h3C);
    add_entry(KIND_IO_RD, 16'h0042, 8'h00);
    add_entry(KIND_INT_ACK, 16'h0038, 8'h00);
    add_entry(KIND_MEM_WR, 16'hFFFF, 8'h5A);
    add_entry(KIND_FETCH, 16'hFFFF, 8'h00);
    // Mostly fetches, every fourth entry of any kind
    for (int i = 0; i < N_RAND; i++) begin
      rk = (i % 4 == 3) ? cycle_kind_t'({$random(seed)} % 6) : KIND_FETCH;
      ra = addr_t'($random(seed));
      rw = data_t'($random(seed));
      add_entry(rk, ra, rw);
    end
    tbl_ready = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    foreach (tbl[i]) begin
      cur_idx = i;
      run_entry(tbl[i]);
    end
    repeat (2) @(negedge clk);
    if (dut0.u_checker.viol_cnt == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Bus protocol assertions failed %0d times", dut0.u_checker.viol_cnt);
      $display("Test failures found");
      $fatal(1, "Protocol assertion failures");
    end
  end

  // A failing bound assertion stops the run right away
  initial begin
    wait (dut0.u_checker.viol_cnt != 0);
    $display("A bus protocol assertion failed, see the error above");
    $display("Test failures found");
    $fatal(1, "Protocol assertion failure");
  end

  // About 20 clocks per entry, plus reset
  initial begin
    wait (tbl_ready);
    #((tbl.size() + 10) * 20 * CLK_PERIOD);
    $display("Timeout: the engine stopped answering requests and ack never came");
    $display("Test failures found");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

//--- all.f
z80_bus_pkg.sv
tstate_timer.sv
mcycle_fsm.sv
bus_strobe_gen.sv
bus_data_path.sv
z80_bus_top.sv
z80_bus_checker.sv
tb_z80_bus.sv

//--- Bender.yml
package:
  name: z80_bus

sources:
  # Package first, then the blocks, then the top level
  - z80_bus_pkg.sv
  - tstate_timer.sv
  - mcycle_fsm.sv
  - bus_strobe_gen.sv
  - bus_data_path.sv
  - z80_bus_top.sv
  # Verification only
  - target: test
    files:
      - z80_bus_checker.sv
      - tb_z80_bus.sv
